// File: hw/board_pkg.sv
// ##################################################################
// Widths and types shared by the board input section
// Raw joystick words are active high, direction bits sit at the bottom
// Button index rules assume 2 to 6 buttons per player
// ##################################################################

package board_pkg;

    localparam int NUM_PLAYERS = 4;
    localparam int DIR_W       = 4;   // right, left, down, up in bits 0..3
    localparam int JOY_RAW_W   = 16;
    localparam int JOY_GAME_W  = 10;

    typedef logic [JOY_RAW_W-1:0]  joy_raw_t;   // 1 means pressed
    typedef logic [JOY_GAME_W-1:0] joy_game_t;

    // Button positions move up with the number of fire buttons
    function automatic int start_bit(input int buttons);
        return 6 + (buttons - 2);
    endfunction

    function automatic int coin_bit(input int buttons);
        return 7 + (buttons - 2);
    endfunction

    function automatic int pause_bit(input int buttons);
        return 8 + (buttons - 2);
    endfunction

    // Game reset sequencing
    typedef enum logic [1:0] {
        RST_HOLD,     // Cause present
        RST_STRETCH,  // Counting down after the cause left
        RST_RUN
    } reset_state_t;

endpackage

// File: hw/reset_gen.sv
// ##################################################################
// Game reset with stretch. GAME_RST_LEN must be 1 or more
// game_rst is high one cycle after any cause, then GAME_RST_LEN more
// ##################################################################
`timescale 1ns/1ps

module reset_gen #(
    parameter int GAME_RST_LEN = 16
)(
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst
);

    localparam int CNT_W = $clog2(GAME_RST_LEN + 1);

    board_pkg::reset_state_t state;
    logic [CNT_W-1:0]        cnt;
    logic                    cause;

    assign cause = rst_req | downloading | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (rst || cause) begin   // External reset is one more cause
            state <= board_pkg::RST_HOLD;
            cnt   <= '0;
        end else begin
            case (state)
                board_pkg::RST_HOLD: begin
                    state <= board_pkg::RST_STRETCH;
                    cnt   <= CNT_W'(GAME_RST_LEN - 1);
                end
                board_pkg::RST_STRETCH: begin
                    if (cnt == '0) begin
                        state <= board_pkg::RST_RUN;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                board_pkg::RST_RUN: begin
                    state <= board_pkg::RST_RUN;
                end
                default: begin
                    state <= board_pkg::RST_HOLD;  // Unused encoding
                end
            endcase
        end
    end

    // Low only once the stretch has run out
    assign game_rst = (state != board_pkg::RST_RUN);

endmodule

// File: hw/joy_sync.sv
// ##################################################################
// Input register for the board joysticks and mode levels
// Words are taken as quasi static, one flop stage only
// ##################################################################
`timescale 1ns/1ps

module joy_sync (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                four_way,
    input  logic                rotate_en,
    input  board_pkg::joy_raw_t board_joystick [board_pkg::NUM_PLAYERS],
    output board_pkg::joy_raw_t sync_joy [board_pkg::NUM_PLAYERS],
    output logic                sync_four_way,
    output logic                sync_rotate_en
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                sync_joy[i] <= '0;    // Nothing pressed
            end
            sync_four_way  <= 1'b0;
            sync_rotate_en <= 1'b0;
        end else begin
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                sync_joy[i] <= board_joystick[i];
            end
            sync_four_way  <= four_way;
            sync_rotate_en <= rotate_en;
        end
    end

endmodule

// File: hw/joy_4way.sv
// ##################################################################
// 4-way direction filter, one register stage for the whole word
// A diagonal keeps the last accepted direction on the output
// ##################################################################
`timescale 1ns/1ps

module joy_4way (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                four_way,
    input  board_pkg::joy_raw_t joy_in,
    output board_pkg::joy_raw_t joy_out
);

    localparam int CNT_W = $clog2(board_pkg::DIR_W + 1);

    logic [CNT_W-1:0] dir_cnt;
    logic             dir_ok;

    // Number of pressed directions
    always_comb begin
        dir_cnt = '0;
        for (int i = 0; i < board_pkg::DIR_W; i++) begin
            dir_cnt = dir_cnt + CNT_W'(joy_in[i]);
        end
    end

    assign dir_ok = !four_way || (dir_cnt <= CNT_W'(1));

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_out <= '0;
        end else begin
            // Buttons stay aligned with the directions
            joy_out[board_pkg::JOY_RAW_W-1:board_pkg::DIR_W] <=
                joy_in[board_pkg::JOY_RAW_W-1:board_pkg::DIR_W];
            if (dir_ok) begin
                joy_out[board_pkg::DIR_W-1:0] <= joy_in[board_pkg::DIR_W-1:0];
            end
        end
    end

endmodule

// File: hw/input_map.sv
// ##################################################################
// Maps filtered joysticks to game inputs, handles pause and layers
// All game outputs are inverted when ACTIVE_LOW is set
// Pause buttons are only read from players 1 and 2
// ##################################################################
`timescale 1ns/1ps

module input_map #(
    parameter int BUTTONS    = 4,
    parameter bit ACTIVE_LOW = 1'b1
)(
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 rotate_en,
    input  logic                 downloading,
    input  logic                 key_pause,
    input  logic                 key_reset,
    input  logic                 key_service,
    input  logic [3:0]           key_gfx,
    input  board_pkg::joy_raw_t  filt_joy [board_pkg::NUM_PLAYERS],
    output board_pkg::joy_game_t game_joystick [board_pkg::NUM_PLAYERS],
    output logic [3:0]           game_coin,
    output logic [3:0]           game_start,
    output logic [3:0]           gfx_en,
    output logic                 game_service,
    output logic                 game_pause,
    output logic                 soft_rst
);

    localparam int START_BIT = board_pkg::start_bit(BUTTONS);
    localparam int COIN_BIT  = board_pkg::coin_bit(BUTTONS);
    localparam int PAUSE_BIT = board_pkg::pause_bit(BUTTONS);

    localparam board_pkg::joy_game_t JOY_INV = {board_pkg::JOY_GAME_W{ACTIVE_LOW}};
    localparam logic [3:0]           BTN_INV = {board_pkg::NUM_PLAYERS{ACTIVE_LOW}};

    logic [3:0] coin_raw;
    logic [3:0] start_raw;
    logic [3:0] last_gfx;
    logic [3:0] gfx_edge;
    logic       last_pause;
    logic       last_joypause;
    logic       last_reset;
    logic       joy_pause;
    logic       pause_edge;

    // Vertical games turn the stick a quarter
    function automatic board_pkg::joy_game_t rotate_dirs(
        input board_pkg::joy_raw_t joy,
        input logic                rot
    );
        board_pkg::joy_game_t low;
        low = joy[board_pkg::JOY_GAME_W-1:0];
        if (rot) begin
            low[board_pkg::DIR_W-1:0] = {joy[0], joy[1], joy[3], joy[2]};
        end
        return low;
    endfunction

    always_comb begin
        for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
            coin_raw[i]  = filt_joy[i][COIN_BIT];   // Player 1 in bit 0
            start_raw[i] = filt_joy[i][START_BIT];
        end
    end

    assign joy_pause  = filt_joy[0][PAUSE_BIT] | filt_joy[1][PAUSE_BIT];
    assign pause_edge = (key_pause & ~last_pause) | (joy_pause & ~last_joypause);
    assign gfx_edge   = key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                game_joystick[i] <= JOY_INV;     // Idle level
            end
            game_coin     <= BTN_INV;
            game_start    <= BTN_INV;
            game_service  <= ACTIVE_LOW;
            game_pause    <= 1'b0;
            gfx_en        <= 4'hf;               // All layers on
            soft_rst      <= 1'b0;
            last_gfx      <= 4'h0;
            last_pause    <= 1'b0;
            last_joypause <= 1'b0;
            last_reset    <= 1'b0;
        end else begin
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                game_joystick[i] <= rotate_dirs(filt_joy[i], rotate_en) ^ JOY_INV;
            end
            game_coin    <= coin_raw ^ BTN_INV;
            game_start   <= start_raw ^ BTN_INV;
            game_service <= key_service ^ ACTIVE_LOW;

            soft_rst <= key_reset & ~last_reset;  // One cycle pulse
            gfx_en   <= gfx_en ^ gfx_edge;

            // ROM loading always leaves the game running
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end

            last_gfx      <= key_gfx;
            last_pause    <= key_pause;
            last_joypause <= joy_pause;
            last_reset    <= key_reset;
        end
    end

endmodule

// File: hw/board_inputs.sv
// ##################################################################
// Input and reset section of the board wrapper, single clock clk_sys
// Joystick to game output latency is 3 cycles, keys take 1 cycle
// rst is synchronous and comes from outside
// ##################################################################
`timescale 1ns/1ps

module board_inputs #(
    parameter int BUTTONS      = 4,
    parameter bit ACTIVE_LOW   = 1'b1,
    parameter int GAME_RST_LEN = 16
)(
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 rst_req,
    input  logic                 downloading,
    input  logic                 four_way,
    input  logic                 rotate_en,
    input  logic                 key_pause,
    input  logic                 key_reset,
    input  logic                 key_service,
    input  logic [3:0]           key_gfx,
    input  board_pkg::joy_raw_t  board_joystick1,
    input  board_pkg::joy_raw_t  board_joystick2,
    input  board_pkg::joy_raw_t  board_joystick3,
    input  board_pkg::joy_raw_t  board_joystick4,
    output board_pkg::joy_game_t game_joystick1,
    output board_pkg::joy_game_t game_joystick2,
    output board_pkg::joy_game_t game_joystick3,
    output board_pkg::joy_game_t game_joystick4,
    output logic [3:0]           game_coin,
    output logic [3:0]           game_start,
    output logic                 game_service,
    output logic                 game_pause,
    output logic [3:0]           gfx_en,
    output logic                 game_rst
);

    board_pkg::joy_raw_t  board_joy [board_pkg::NUM_PLAYERS];
    board_pkg::joy_raw_t  sync_joy  [board_pkg::NUM_PLAYERS];
    board_pkg::joy_raw_t  filt_joy  [board_pkg::NUM_PLAYERS];
    board_pkg::joy_game_t game_joy  [board_pkg::NUM_PLAYERS];
    logic                 sync_four_way;
    logic                 sync_rotate_en;
    logic                 soft_rst;

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    joy_sync u_sync (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .four_way       ( four_way       ),
        .rotate_en      ( rotate_en      ),
        .board_joystick ( board_joy      ),
        .sync_joy       ( sync_joy       ),
        .sync_four_way  ( sync_four_way  ),
        .sync_rotate_en ( sync_rotate_en )
    );

    // One filter per player
    for (genvar i = 0; i < board_pkg::NUM_PLAYERS; i++) begin : g_filt
        joy_4way u_4way (
            .clk_sys  ( clk_sys       ),
            .rst      ( rst           ),
            .four_way ( sync_four_way ),
            .joy_in   ( sync_joy[i]   ),
            .joy_out  ( filt_joy[i]   )
        );
    end

    input_map #(
        .BUTTONS    ( BUTTONS    ),
        .ACTIVE_LOW ( ACTIVE_LOW )
    ) u_map (
        .clk_sys       ( clk_sys        ),
        .rst           ( rst            ),
        .rotate_en     ( sync_rotate_en ),
        .downloading   ( downloading    ),
        .key_pause     ( key_pause      ),
        .key_reset     ( key_reset      ),
        .key_service   ( key_service    ),
        .key_gfx       ( key_gfx        ),
        .filt_joy      ( filt_joy       ),
        .game_joystick ( game_joy       ),
        .game_coin     ( game_coin      ),
        .game_start    ( game_start     ),
        .gfx_en        ( gfx_en         ),
        .game_service  ( game_service   ),
        .game_pause    ( game_pause     ),
        .soft_rst      ( soft_rst       )
    );

    reset_gen #(
        .GAME_RST_LEN ( GAME_RST_LEN )
    ) u_rst (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst    ( game_rst    )
    );

endmodule

// File: testbench/tb_checks.svh
// ##################################################################
// Tests, compare tasks and reference model of the board input section
// Expects BUTTONS 4, so coin is raw bit 9, start bit 8, pause bit 10
// ##################################################################
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_game_joy(input string name, input board_pkg::joy_game_t got,
                              input board_pkg::joy_game_t exp);
    if (got !== exp) begin
        errors++;
        $display("FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        errors++;
        $display("FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

// Reference for one game joystick word
function automatic board_pkg::joy_game_t expect_joy(input board_pkg::joy_raw_t w,
                                                    input logic rot);
    board_pkg::joy_game_t v;
    v = w[9:0];
    if (rot) begin
        v[0] = w[2];
        v[1] = w[3];
        v[2] = w[1];
        v[3] = w[0];
    end
    return v ^ {10{ACTIVE_LOW}};
endfunction

task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $finish;
endtask

// Counts negedge samples with game_rst high, from its rise to its fall
task automatic count_rst_high(input string cause, input int exp);
    int n;
    int t;
    n = 0;
    t = 0;
    do begin
        @(negedge clk_sys);
        t++;
        if (t > TIMEOUT) stop_on_timeout({"game_rst to rise after ", cause});
    end while (!game_rst);
    t = 0;
    while (game_rst) begin
        n++;
        @(negedge clk_sys);
        t++;
        if (t > TIMEOUT) stop_on_timeout({"game_rst to fall after ", cause});
    end
    if (n != exp) begin
        errors++;
        $display("FAILED game_rst high cycles after %s: got %h expected %h", cause, n, exp);
    end
endtask

task automatic wait_rst_low();
    int t;
    t = 0;
    while (game_rst) begin
        @(negedge clk_sys);
        t++;
        if (t > TIMEOUT) stop_on_timeout("game_rst to fall");
    end
endtask

task automatic idle_values();
    for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
        check_game_joy($sformatf("game_joystick%0d", i + 1), game_joy[i], 10'h3ff);
    end
    check_nibble("game_coin", game_coin, 4'hf);
    check_nibble("game_start", game_start, 4'hf);
    check_bit("game_service", game_service, 1'b1);
    check_bit("game_pause", game_pause, 1'b0);
    check_nibble("gfx_en", gfx_en, 4'hf);
    check_bit("game_rst", game_rst, 1'b1);
endtask
`endif

// File: testbench/tb_board_inputs.sv
// ##################################################################
// Directed testbench for board_inputs, BUTTONS 4 and active low outputs
// Joystick checks wait the fixed 3 cycle pipeline latency
// ##################################################################
`timescale 1ns/1ps

module tb_board_inputs;

    localparam int BUTTONS      = 4;
    localparam bit ACTIVE_LOW   = 1'b1;
    localparam int GAME_RST_LEN = 16;
    localparam int TIMEOUT      = 200;

    logic                 clk_sys;
    logic                 rst;
    logic                 rst_req;
    logic                 downloading;
    logic                 four_way;
    logic                 rotate_en;
    logic                 key_pause;
    logic                 key_reset;
    logic                 key_service;
    logic [3:0]           key_gfx;
    board_pkg::joy_raw_t  joy_drv  [board_pkg::NUM_PLAYERS];
    board_pkg::joy_game_t game_joy [board_pkg::NUM_PLAYERS];
    logic [3:0]           game_coin;
    logic [3:0]           game_start;
    logic                 game_service;
    logic                 game_pause;
    logic [3:0]           gfx_en;
    logic                 game_rst;
    int                   errors;
    int unsigned          seed_val;

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    board_inputs #(
        .BUTTONS      ( BUTTONS      ),
        .ACTIVE_LOW   ( ACTIVE_LOW   ),
        .GAME_RST_LEN ( GAME_RST_LEN )
    ) uut (
        .clk_sys         ( clk_sys      ),
        .rst             ( rst          ),
        .rst_req         ( rst_req      ),
        .downloading     ( downloading  ),
        .four_way        ( four_way     ),
        .rotate_en       ( rotate_en    ),
        .key_pause       ( key_pause    ),
        .key_reset       ( key_reset    ),
        .key_service     ( key_service  ),
        .key_gfx         ( key_gfx      ),
        .board_joystick1 ( joy_drv[0]   ),
        .board_joystick2 ( joy_drv[1]   ),
        .board_joystick3 ( joy_drv[2]   ),
        .board_joystick4 ( joy_drv[3]   ),
        .game_joystick1  ( game_joy[0]  ),
        .game_joystick2  ( game_joy[1]  ),
        .game_joystick3  ( game_joy[2]  ),
        .game_joystick4  ( game_joy[3]  ),
        .game_coin       ( game_coin    ),
        .game_start      ( game_start   ),
        .game_service    ( game_service ),
        .game_pause      ( game_pause   ),
        .gfx_en          ( gfx_en       ),
        .game_rst        ( game_rst     )
    );

    `include "tb_checks.svh"

    task automatic random_words(input logic rot);
        board_pkg::joy_raw_t w [board_pkg::NUM_PLAYERS];
        logic [3:0]          exp_coin;
        logic [3:0]          exp_start;
        for (int k = 0; k < 6; k++) begin
            @(posedge clk_sys);
            four_way  <= 1'b0;
            rotate_en <= rot;
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                w[i]         = board_pkg::joy_raw_t'($urandom);
                joy_drv[i]  <= w[i];
                exp_coin[i]  = w[i][9] ^ ACTIVE_LOW;
                exp_start[i] = w[i][8] ^ ACTIVE_LOW;
            end
            repeat (3) @(posedge clk_sys);   // sync, filter, map
            @(negedge clk_sys);
            for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
                check_game_joy($sformatf("game_joystick%0d", i + 1), game_joy[i],
                               expect_joy(w[i], rot));
            end
            check_nibble("game_coin", game_coin, exp_coin);
            check_nibble("game_start", game_start, exp_start);
        end
    endtask

    // Player 1 word through the 3 stage path
    task automatic drive_p1(input board_pkg::joy_raw_t w);
        @(posedge clk_sys);
        joy_drv[0] <= w;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic four_way_filter();
        @(posedge clk_sys);
        four_way  <= 1'b1;
        rotate_en <= 1'b0;
        for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
            joy_drv[i] <= '0;
        end
        drive_p1(16'h0001);                  // Right only
        check_game_joy("game_joystick1 single", game_joy[0], 10'h3fe);
        drive_p1(16'h020a);                  // Left and up plus coin
        check_game_joy("game_joystick1 diagonal", game_joy[0], 10'h1fe);
        drive_p1(16'h0000);
        check_game_joy("game_joystick1 released", game_joy[0], 10'h3ff);
        @(posedge clk_sys);
        four_way <= 1'b0;
    endtask

    task automatic pause_toggle();
        @(posedge clk_sys);
        downloading <= 1'b1;
        @(posedge clk_sys);
        downloading <= 1'b0;
        @(negedge clk_sys);
        check_bit("game_pause after download", game_pause, 1'b0);
        wait_rst_low();
        @(posedge clk_sys);
        key_pause <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_pause key edge", game_pause, 1'b1);
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_pause key held", game_pause, 1'b1);
        @(posedge clk_sys);
        key_pause  <= 1'b0;
        joy_drv[1] <= 16'h0400;              // Player 2 pause button
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_pause player 2", game_pause, 1'b0);
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_pause player 2 held", game_pause, 1'b0);
        @(posedge clk_sys);
        joy_drv[1] <= '0;
        repeat (3) @(posedge clk_sys);
        key_pause <= 1'b1;
        @(posedge clk_sys);
        key_pause <= 1'b0;
        @(negedge clk_sys);
        check_bit("game_pause second edge", game_pause, 1'b1);
        @(posedge clk_sys);
        downloading <= 1'b1;
        @(posedge clk_sys);
        downloading <= 1'b0;
        @(negedge clk_sys);
        check_bit("game_pause forced by download", game_pause, 1'b0);
        wait_rst_low();
    endtask

    task automatic soft_reset_layers();
        logic [3:0] exp_gfx;
        @(posedge clk_sys);
        key_reset <= 1'b1;
        @(posedge clk_sys);
        key_reset <= 1'b0;
        count_rst_high("key_reset", 1 + GAME_RST_LEN);
        @(posedge clk_sys);
        rst_req <= 1'b1;
        repeat (3) @(posedge clk_sys);
        rst_req <= 1'b0;                     // Stretch counts from here
        count_rst_high("rst_req", 1 + GAME_RST_LEN);
        exp_gfx = 4'hf;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_sys);
            key_gfx <= 4'(1 << i);
            @(posedge clk_sys);
            @(negedge clk_sys);
            exp_gfx = exp_gfx ^ 4'(1 << i);
            check_nibble("gfx_en edge", gfx_en, exp_gfx);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_nibble("gfx_en held", gfx_en, exp_gfx);
            @(posedge clk_sys);
            key_gfx <= 4'h0;
        end
        @(posedge clk_sys);
        key_service <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_service", game_service, 1'b0);
        @(posedge clk_sys);
        key_service <= 1'b0;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_service released", game_service, 1'b1);
    endtask

    initial begin
        errors      = 0;
        seed_val    = $urandom(87376);
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        four_way    = 1'b0;
        rotate_en   = 1'b0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = 4'h0;
        for (int i = 0; i < board_pkg::NUM_PLAYERS; i++) begin
            joy_drv[i] = '0;
        end

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        idle_values();
        @(posedge clk_sys);
        rst <= 1'b0;                         // Third reset cycle ends here
        count_rst_high("external reset", 1 + GAME_RST_LEN);

        random_words(1'b0);
        random_words(1'b1);
        four_way_filter();
        pause_toggle();
        soft_reset_layers();

        repeat (2) @(posedge clk_sys);
        $display("Checks done, error count %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+testbench
hw/board_pkg.sv
hw/reset_gen.sv
hw/joy_sync.sv
hw/joy_4way.sv
hw/input_map.sv
hw/board_inputs.sv
testbench/tb_board_inputs.sv
